// ==== common/cache_pkg.sv ====
package cache_pkg;

   // address and data geometry
   localparam int addr_w   = 12;
   localparam int data_w   = 16;
   localparam int offset_w = 2;
   localparam int index_w  = 3;
   localparam int tag_w    = 7;

   localparam int num_lines  = 8;
   localparam int line_words = 4;

   // main memory interleaved by word offset
   localparam int num_banks        = 4;
   localparam int bank_busy_cycles = 2;
   localparam int bank_w           = $clog2(num_banks);
   localparam int bank_words       = (2 ** addr_w) / num_banks;
   localparam int busy_w           = $clog2(bank_busy_cycles + 1);

   typedef enum logic [2:0] {
      idle          = 3'd0,
      compare_read  = 3'd1,
      compare_write = 3'd2,
      mem_read_miss = 3'd3,
      wait_fill     = 3'd4,
      access_read   = 3'd5,
      access_write  = 3'd6,
      done          = 3'd7
   } ctrl_state_t;

   typedef struct packed {
      logic              rd;
      logic              wr;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;
   } cache_req_t;

   typedef struct packed {
      logic hit;
      logic valid;
      logic dirty;
   } line_status_t;

   typedef struct packed {
      logic              rd;
      logic              wr;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;
   } mem_req_t;

   // cache_in high selects the memory word over the client word
   typedef struct packed {
      logic                comp;
      logic                write;
      logic                valid_in;
      logic                cache_in;
      logic [offset_w-1:0] offset;
   } array_ctrl_t;

   function automatic logic [tag_w-1:0] addr_tag(input logic [addr_w-1:0] addr);
      return addr[addr_w-1 -: tag_w];
   endfunction

   function automatic logic [index_w-1:0] addr_index(input logic [addr_w-1:0] addr);
      return addr[offset_w +: index_w];
   endfunction

   function automatic logic [offset_w-1:0] addr_offset(input logic [addr_w-1:0] addr);
      return addr[offset_w-1:0];
   endfunction

endpackage

// ==== cache_ctrl/cache_array.sv ====
`timescale 1ns/1ps

module cache_array import cache_pkg::*; (
   input  logic               clk,
   input  logic               arst_n,
   input  logic [index_w-1:0] index,
   input  logic [tag_w-1:0]   tag,
   input  logic [data_w-1:0]  wdata_client,
   input  logic [data_w-1:0]  wdata_mem,
   input  array_ctrl_t        actl,
   output line_status_t       status,
   output logic [tag_w-1:0]   stored_tag,
   output logic [data_w-1:0]  rdata
);

   logic [tag_w-1:0]     tag_mem  [num_lines];
   logic [data_w-1:0]    data_mem [num_lines][line_words];
   logic [num_lines-1:0] valid_q;
   logic [num_lines-1:0] dirty_q;
   logic                 tag_match;
   logic                 word_we;
   logic [data_w-1:0]    wdata;

   assign stored_tag = tag_mem[index];
   assign tag_match  = (stored_tag == tag);

   assign status.valid = valid_q[index];
   assign status.dirty = dirty_q[index];
   assign status.hit   = valid_q[index] & tag_match;

   // a compare write only goes through on a hit
   assign word_we = actl.write & (~actl.comp | status.hit);
   assign wdata   = actl.cache_in ? wdata_mem : wdata_client;

   assign rdata = data_mem[index][actl.offset];

   always_ff @(posedge clk) begin
      if (word_we) begin
         data_mem[index][actl.offset] <= wdata;
         tag_mem[index]               <= tag;
      end
   end

   // fill words leave the line clean, client words make it dirty
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (word_we) begin
         valid_q[index] <= actl.valid_in;
         dirty_q[index] <= ~actl.cache_in;
      end
   end

endmodule

// ==== cache_ctrl/cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller import cache_pkg::*; (
   input  logic                clk,
   input  logic                arst_n,
   input  cache_req_t          req,
   input  line_status_t        status,
   input  logic                mem_stall,
   input  logic                mem_rvalid,
   output array_ctrl_t         actl,
   output logic                mem_rd,
   output logic                mem_wr,
   output logic [offset_w-1:0] counter,
   output logic                done,
   output logic                hit
);

   ctrl_state_t         state;
   ctrl_state_t         state_d;
   logic [offset_w-1:0] counter_d;
   array_ctrl_t         actl_d;
   logic                mem_rd_d;
   logic                mem_wr_d;
   logic                done_d;
   logic                hit_d;
   logic [offset_w-1:0] req_offset;
   logic                line_dirty;
   logic                last_word;

   assign req_offset = addr_offset(req.addr);
   assign line_dirty = status.valid & status.dirty;
   assign last_word  = (counter == offset_w'(line_words - 1));

   // next state and next outputs are registered below
   always_comb begin
      state_d         = state;
      counter_d       = counter;
      actl_d.comp     = 1'b0;
      actl_d.write    = 1'b0;
      actl_d.valid_in = 1'b0;
      actl_d.cache_in = 1'b0;
      actl_d.offset   = req_offset;
      mem_rd_d        = 1'b0;
      mem_wr_d        = 1'b0;
      done_d          = 1'b0;
      hit_d           = 1'b0;

      case (state)
         idle: begin
            if (req.rd) begin
               actl_d.comp = 1'b1;
               state_d     = compare_read;
            end else if (req.wr) begin
               // array only writes this if the tag matches
               actl_d.comp     = 1'b1;
               actl_d.write    = 1'b1;
               actl_d.valid_in = 1'b1;
               state_d         = compare_write;
            end
         end

         compare_read, compare_write: begin
            if (status.hit) begin
               counter_d = '0;
               done_d    = 1'b1;
               hit_d     = 1'b1;
               state_d   = cache_pkg::done;
            end else if (line_dirty) begin
               // victim goes back to memory first
               mem_wr_d      = 1'b1;
               actl_d.offset = counter;
               state_d       = access_read;
            end else begin
               mem_rd_d = 1'b1;
               state_d  = mem_read_miss;
            end
         end

         access_read: begin
            if (mem_stall) begin
               mem_wr_d      = 1'b1;
               actl_d.offset = counter;
            end else if (last_word) begin
               counter_d = '0;
               mem_rd_d  = 1'b1;
               state_d   = mem_read_miss;
            end else begin
               counter_d     = counter + 1'b1;
               mem_wr_d      = 1'b1;
               actl_d.offset = counter_d;
            end
         end

         mem_read_miss: begin
            if (mem_stall) begin
               mem_rd_d = 1'b1;
            end else begin
               state_d = wait_fill;
            end
         end

         wait_fill: begin
            if (mem_rvalid) begin
               // the write lands next cycle while memory still holds rdata
               actl_d.write    = 1'b1;
               actl_d.valid_in = 1'b1;
               actl_d.cache_in = 1'b1;
               actl_d.offset   = counter;
               if (last_word) begin
                  state_d = access_write;
               end else begin
                  counter_d = counter + 1'b1;
                  mem_rd_d  = 1'b1;
                  state_d   = mem_read_miss;
               end
            end
         end

         access_write: begin
            // line is complete and the client write goes in with done
            if (req.wr) begin
               actl_d.write    = 1'b1;
               actl_d.valid_in = 1'b1;
            end
            counter_d = '0;
            done_d    = 1'b1;
            state_d   = cache_pkg::done;
         end

         cache_pkg::done: begin
            state_d = idle;
         end

         default: begin
            state_d = idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= idle;
         counter <= '0;
         actl    <= '0;
         mem_rd  <= 1'b0;
         mem_wr  <= 1'b0;
         done    <= 1'b0;
         hit     <= 1'b0;
      end else begin
         state   <= state_d;
         counter <= counter_d;
         actl    <= actl_d;
         mem_rd  <= mem_rd_d;
         mem_wr  <= mem_wr_d;
         done    <= done_d;
         hit     <= hit_d;
      end
   end

endmodule

// ==== src/banked_memory.sv ====
`timescale 1ns/1ps

module banked_memory import cache_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  mem_req_t          req,
   output logic              stall,
   output logic [data_w-1:0] rdata,
   output logic              rvalid
);

   logic [data_w-1:0]        bank_mem [num_banks][bank_words] = '{default: '0};
   logic [busy_w-1:0]        busy_cnt [num_banks];
   logic [bank_w-1:0]        bank_sel;
   logic [addr_w-bank_w-1:0] row;
   logic                     access;
   logic                     accept;
   logic                     rd_vld1;
   logic [data_w-1:0]        rd_data1;

   // low address bits pick the bank
   assign bank_sel = req.addr[bank_w-1:0];
   assign row      = req.addr[addr_w-1:bank_w];

   assign access = req.rd | req.wr;
   assign stall  = access & (busy_cnt[bank_sel] != '0);
   assign accept = access & ~stall;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < num_banks; b++) begin
            busy_cnt[b] <= '0;
         end
         rd_vld1 <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         for (int b = 0; b < num_banks; b++) begin
            if (accept && (bank_sel == bank_w'(b))) begin
               busy_cnt[b] <= busy_w'(bank_busy_cycles);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
         rd_vld1 <= accept & req.rd;
         rvalid  <= rd_vld1;
      end
   end

   // rdata holds until the next read returns
   always_ff @(posedge clk) begin
      if (accept && req.wr) begin
         bank_mem[bank_sel][row] <= req.wdata;
      end
      if (accept && req.rd) begin
         rd_data1 <= bank_mem[bank_sel][row];
      end
      if (rd_vld1) begin
         rdata <= rd_data1;
      end
   end

endmodule

// ==== src/cache_system.sv ====
`timescale 1ns/1ps

module cache_system import cache_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  cache_req_t        req,
   output logic [data_w-1:0] rdata,
   output logic              done,
   output logic              hit
);

   array_ctrl_t         actl;
   line_status_t        status;
   mem_req_t            mem_req;
   logic [tag_w-1:0]    stored_tag;
   logic [tag_w-1:0]    line_tag;
   logic [data_w-1:0]   line_rdata;
   logic [data_w-1:0]   mem_rdata;
   logic                mem_rd;
   logic                mem_wr;
   logic                mem_stall;
   logic                mem_rvalid;
   logic [offset_w-1:0] counter;

   // writeback targets the victim line, fill the requested one
   assign line_tag = mem_wr ? stored_tag : addr_tag(req.addr);

   assign mem_req.rd    = mem_rd;
   assign mem_req.wr    = mem_wr;
   assign mem_req.addr  = {line_tag, addr_index(req.addr), counter};
   assign mem_req.wdata = line_rdata;

   assign rdata = line_rdata;

   cache_controller cache_controller_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .req        (req),
      .status     (status),
      .mem_stall  (mem_stall),
      .mem_rvalid (mem_rvalid),
      .actl       (actl),
      .mem_rd     (mem_rd),
      .mem_wr     (mem_wr),
      .counter    (counter),
      .done       (done),
      .hit        (hit)
   );

   cache_array cache_array_i (
      .clk          (clk),
      .arst_n       (arst_n),
      .index        (addr_index(req.addr)),
      .tag          (addr_tag(req.addr)),
      .wdata_client (req.wdata),
      .wdata_mem    (mem_rdata),
      .actl         (actl),
      .status       (status),
      .stored_tag   (stored_tag),
      .rdata        (line_rdata)
   );

   banked_memory banked_memory_i (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (mem_req),
      .stall  (mem_stall),
      .rdata  (mem_rdata),
      .rvalid (mem_rvalid)
   );

endmodule

// ==== tb/cache_checker.sv ====
`timescale 1ns/1ps

module cache_checker import cache_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  cache_req_t        req,
   input  logic [data_w-1:0] rdata,
   input  logic              done,
   input  logic              hit,
   output int                error_count
);

   // reference memory holds the last value written to each word
   logic [data_w-1:0]    ref_mem [2**addr_w];
   logic [tag_w-1:0]     model_tag [num_lines];
   logic [num_lines-1:0] model_valid;
   logic                 active;
   int                   wait_cycles;

   initial begin
      for (int a = 0; a < 2**addr_w; a++) begin
         ref_mem[a] = '0;
      end
      model_valid = '0;
      active      = 1'b0;
      wait_cycles = 0;
      error_count = 0;
   end

   // outputs and request are both stable at the falling edge
   always @(negedge clk) begin
      logic [tag_w-1:0]   tag;
      logic [index_w-1:0] index;
      logic               exp_hit;
      tag   = req.addr[addr_w-1 -: tag_w];
      index = req.addr[offset_w +: index_w];
      if (!arst_n) begin
         active      = 1'b0;
         model_valid = '0;
      end else begin
         if (!active && (req.rd || req.wr)) begin
            active      = 1'b1;
            wait_cycles = 0;
         end else if (active) begin
            wait_cycles++;
         end
         if (done === 1'b1) begin
            // a request that only just appeared cannot be answered yet
            if (!active || wait_cycles == 0) begin
               $display("time %0t: done pulse seen with no request waiting for it", $time);
               error_count++;
            end else begin
               exp_hit = model_valid[index] && (model_tag[index] == tag);
               if (hit !== exp_hit) begin
                  $display("FAILED time=%0t signal=hit expected=%0b actual=%0b",
                           $time, exp_hit, hit);
                  error_count++;
               end
               // hits answer two cycles after the request appears
               if (exp_hit && wait_cycles != 2) begin
                  $display("FAILED time=%0t signal=done expected=%0d cycles actual=%0d cycles",
                           $time, 2, wait_cycles);
                  error_count++;
               end
               if (req.rd) begin
                  if (rdata !== ref_mem[req.addr]) begin
                     $display("FAILED time=%0t signal=rdata expected=%h actual=%h",
                              $time, ref_mem[req.addr], rdata);
                     error_count++;
                  end
               end else begin
                  ref_mem[req.addr] = req.wdata;
               end
               model_tag[index]   = tag;
               model_valid[index] = 1'b1;
               active             = 1'b0;
            end
         end else if (done !== 1'b0) begin
            $display("time %0t: done is neither high nor low", $time);
            error_count++;
         end
      end
   end

endmodule

// ==== tb/tb_cache_system.sv ====
`timescale 1ns/1ps

module tb_cache_system import cache_pkg::*; ();

   localparam int num_requests   = 400;
   localparam int reset_cycles   = 16;
   localparam int cycles_per_req = 24;
   localparam int timeout_cycles = num_requests * cycles_per_req + reset_cycles;
   localparam int drive_delay    = 2;

   logic              clk;
   logic              arst_n;
   cache_req_t        req;
   logic [data_w-1:0] rdata;
   logic              done;
   logic              hit;
   int                error_count;
   int                requests_done = 0;
   int                timeouts = 0;
   int                cycle_count = 0;
   logic [31:0]       lcg_state;

   always #10 clk = ~clk;

   cache_system cache_system_i (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (req),
      .rdata  (rdata),
      .done   (done),
      .hit    (hit)
   );

   cache_checker cache_checker_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .req         (req),
      .rdata       (rdata),
      .done        (done),
      .hit         (hit),
      .error_count (error_count)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] cur);
      return cur * 32'd1664525 + 32'd1013904223;
   endfunction

   // only four tags are used so lines conflict and dirty lines get evicted
   task automatic drive_random_request();
      logic [31:0]         r;
      logic [tag_w-1:0]    tag;
      logic [index_w-1:0]  index;
      logic [offset_w-1:0] offset;
      lcg_state = lcg_next(lcg_state);
      r         = lcg_state;
      tag       = tag_w'(r[31:30]) * tag_w'(37);
      index     = r[29:27];
      offset    = r[26:25];
      lcg_state = lcg_next(lcg_state);
      req.rd    = ~r[24];
      req.wr    = r[24];
      req.addr  = {tag, index, offset};
      req.wdata = lcg_state[31:16];
   endtask

   task automatic wait_for_done();
      @(negedge clk);
      while (done !== 1'b1) begin
         @(negedge clk);
      end
   endtask

   task automatic finish_run();
      $display("requests=%0d errors=%0d timeouts=%0d", requests_done, error_count, timeouts);
      if (error_count == 0 && timeouts == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   endtask

   initial begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      req       = '0;
      lcg_state = 32'h82249fcd;
      repeat (reset_cycles) @(posedge clk);
      #(drive_delay);
      arst_n = 1'b1;
      // done must stay low through a few quiet cycles
      repeat (3) @(posedge clk);
      #(drive_delay);
      for (int n = 0; n < num_requests; n++) begin
         drive_random_request();
         wait_for_done();
         requests_done++;
         // hold through the done cycle since the array may still write
         @(posedge clk);
         #(drive_delay);
         lcg_state = lcg_next(lcg_state);
         if (lcg_state[31]) begin
            req = '0;
            @(posedge clk);
            #(drive_delay);
         end
      end
      req = '0;
      repeat (4) @(posedge clk);
      finish_run();
   end

   initial begin
      while (cycle_count < timeout_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      timeouts++;
      $display("timeout after %0d cycles, request %0d never received its done",
               cycle_count, requests_done);
      finish_run();
   end

endmodule

// ==== vlog.f ====
common/cache_pkg.sv
cache_ctrl/cache_array.sv
cache_ctrl/cache_controller.sv
src/banked_memory.sv
src/cache_system.sv
tb/cache_checker.sv
tb/tb_cache_system.sv

// ==== Bender.yml ====
package:
  name: cache_system

sources:
  - files:
      - common/cache_pkg.sv
      - cache_ctrl/cache_array.sv
      - cache_ctrl/cache_controller.sv
      - src/banked_memory.sv
      - src/cache_system.sv
  - target: test
    files:
      - tb/cache_checker.sv
      - tb/tb_cache_system.sv
